//--- rope_unit_testdata.txt
# opcode and up to six numbers, one step per line
# load/check_item: index x y kind(0 stone 1 gold 2 diamond) visible moving
# check_pos: degree len end_x end_y; until_*: value cycle_budget
check_pos 165 20 141 50
check_score 0
until_deg 164 100
wait 4
check_pos 164 20 141 50
wait 1
check_pos 163 20 141 50
until_deg 15 1000
wait 2
check_pos 15 20 179 50
wait 3
check_pos 16 20 179 50
busy 1
wait 20
check_pos 16 20 179 50
busy 0
wait 1
check_pos 16 20 179 50
wait 1
check_pos 17 20 179 50
wait 5
press
check_pos 18 20 178 51
until_len 160 5000
wait 2
check_pos 18 160 311 94
until_len 20 1000
wait 6
check_pos 19 20 178 51
check_score 0
load 2 205 74 0 1 0
load 5 185 95 1 1 0
load 11 120 95 2 1 0
load 9 20 200 1 1 0
until_deg 30 200
press
until_len 60 1500
until_len 58 100
check_item 2 205 74 0 1 1
until_len 20 300
wait 4
check_item 2 185 54 0 0 0
check_score 1
until_deg 60 400
press
until_len 60 1500
until_len 58 100
check_item 5 185 95 1 1 1
until_len 20 300
wait 4
check_item 5 165 75 1 0 0
check_score 3
until_deg 120 500
press
until_len 60 1500
until_len 58 100
check_item 11 120 95 2 1 1
until_len 20 300
wait 4
check_item 11 140 75 2 0 0
check_score 8
check_item 9 20 200 1 1 0

//--- rope_unit.f
miner_pkg.sv
angle_trig.sv
key_pulse.sv
item_ram.sv
score_counter.sv
rope_ctrl.sv
rope_unit.sv
tb_rope_unit.sv

//--- tb_rope_unit.sv
//--------------------------------------
// testbench for the claw subsystem
// runs the steps in rope_unit_testdata.txt
// against rope_unit with a short frame
//--------------------------------------
`default_nettype none
`timescale 1ns/1ps

module tb_rope_unit;
    import miner_pkg::*;

    logic                    clock;
    logic                    resetn;
    logic                    enable;
    logic                    go_key;
    logic                    draw_busy;
    logic [item_index_w-1:0] draw_index;
    logic                    load_en;
    logic [item_index_w-1:0] load_index;
    item_t                   load_item;
    rope_pos_t               pos;
    item_t                   draw_item;
    logic [score_w-1:0]      score;

    string op_q[$];
    int    arg_q[$];   // six per step
    int    cycles;
    int    limit;

    rope_unit #(
        .frame_cycles (4)
    ) i_rope_unit (
        .clock      (clock),
        .resetn     (resetn),
        .enable     (enable),
        .go_key     (go_key),
        .draw_busy  (draw_busy),
        .draw_index (draw_index),
        .load_en    (load_en),
        .load_index (load_index),
        .load_item  (load_item),
        .pos        (pos),
        .draw_item  (draw_item),
        .score      (score)
    );

    always #5 clock = ~clock;

    always @(posedge clock) begin
        cycles = cycles + 1;
        if (limit > 0 && cycles > limit) begin
            $display("timeout: the rope never reached the expected state");
            $display("sim failed");
            $fatal(1);
        end
    end

    task automatic compare(input logic [31:0] actual, input logic [31:0] expected,
                           input string what);
        if (actual !== expected) begin
            $display("ERR %0t %s: got %0d, expected %0d", $time, what, actual, expected);
            $display("sim failed");
            $fatal(1);
        end
    endtask

    task automatic load_entry(input int idx, input int x, input int y, input int kind,
                              input int vis, input int mov);
        item_t it;
        it         = '0;
        it.x       = 9'(x);
        it.y       = 8'(y);
        it.kind    = item_kind_e'(kind);
        it.visible = 1'(vis);
        it.moving  = 1'(mov);
        @(posedge clock);
        load_en    <= 1'b1;
        load_index <= item_index_w'(idx);
        load_item  <= it;
        @(posedge clock);
        load_en <= 1'b0;
        @(negedge clock);
    endtask

    // drawer takes the read port for one access
    task automatic check_entry(input int idx, input int x, input int y, input int kind,
                               input int vis, input int mov);
        item_t it;
        @(posedge clock);
        draw_busy  <= 1'b1;
        draw_index <= item_index_w'(idx);
        @(posedge clock);
        @(negedge clock);
        it = draw_item;
        @(posedge clock);
        draw_busy <= 1'b0;
        @(negedge clock);
        compare(it.x, x, $sformatf("item %0d x", idx));
        compare(it.y, y, $sformatf("item %0d y", idx));
        compare(it.kind, kind, $sformatf("item %0d kind", idx));
        compare(it.visible, vis, $sformatf("item %0d visible", idx));
        compare(it.moving, mov, $sformatf("item %0d moving", idx));
    endtask

    task automatic press_go();
        @(posedge clock);
        go_key <= 1'b1;
        @(posedge clock);
        @(posedge clock);
        go_key <= 1'b0;
        @(negedge clock);
    endtask

    task automatic read_steps();
        int    fd;
        int    n;
        string line;
        string opc;
        int    a[6];
        fd = $fopen("rope_unit_testdata.txt", "r");
        if (fd == 0) begin
            $display("could not open the test data file");
            $display("sim failed");
            $fatal(1);
        end
        limit = 2000;   // margin for reset and short steps
        while (!$feof(fd)) begin
            line = "";
            n    = $fgets(line, fd);
            a    = '{0, 0, 0, 0, 0, 0};
            if (n > 1 && line.getc(0) != "#") begin
                n = $sscanf(line, "%s %d %d %d %d %d %d", opc, a[0], a[1], a[2], a[3],
                            a[4], a[5]);
                op_q.push_back(opc);
                foreach (a[j])
                    arg_q.push_back(a[j]);
                if (opc == "wait")
                    limit = limit + a[0];
                else if (opc == "until_deg" || opc == "until_len")
                    limit = limit + a[1];
                else
                    limit = limit + 4;
            end
        end
        $fclose(fd);
    endtask

    task automatic run_step(input string opc, input int k);
        int a[6];
        foreach (a[j])
            a[j] = arg_q[k * 6 + j];
        case (opc)
            "wait":  repeat (a[0]) @(negedge clock);
            "until_deg": while (pos.degree != 10'(a[0])) @(negedge clock);
            "until_len": while (pos.len != 10'(a[0])) @(negedge clock);
            "press": press_go();
            "busy": begin
                @(posedge clock);
                draw_busy <= 1'(a[0]);
                @(negedge clock);
            end
            "load": load_entry(a[0], a[1], a[2], a[3], a[4], a[5]);
            "check_pos": begin
                compare(pos.degree, a[0], "rope degree");
                compare(pos.len, a[1], "rope length");
                compare(pos.end_x, a[2], "rope end x");
                compare(pos.end_y, a[3], "rope end y");
            end
            "check_item": check_entry(a[0], a[1], a[2], a[3], a[4], a[5]);
            "check_score": compare(score, a[0], "score");
            default: begin
                $display("unknown step %s in the test data", opc);
                $display("sim failed");
                $fatal(1);
            end
        endcase
    endtask

    initial begin
        clock      = 1'b0;
        resetn     = 1'b0;
        enable     = 1'b1;
        go_key     = 1'b0;
        draw_busy  = 1'b0;
        draw_index = '0;
        load_en    = 1'b0;
        load_index = '0;
        load_item  = '0;
        cycles     = 0;
        limit      = 0;
        read_steps();
        repeat (3) @(posedge clock);
        resetn <= 1'b1;
        @(negedge clock);
        foreach (op_q[k])
            run_step(op_q[k], k);
        $display("sim passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- rope_unit.sv
//--------------------------------------
// claw subsystem top. rope controller,
// trig table, go key, item memory and
// score. the drawer reads items through
// draw_index and draw_item
//--------------------------------------
`default_nettype none
`timescale 1ns/1ps

module rope_unit #(
    parameter int frame_cycles = 833334
) (
    input  wire                               clock,
    input  wire                               resetn,
    input  wire                               enable,
    input  wire                               go_key,
    input  wire                               draw_busy,
    input  wire [miner_pkg::item_index_w-1:0] draw_index,
    input  wire                               load_en,
    input  wire [miner_pkg::item_index_w-1:0] load_index,
    input  wire miner_pkg::item_t             load_item,
    output miner_pkg::rope_pos_t              pos,
    output miner_pkg::item_t                  draw_item,
    output logic [miner_pkg::score_w-1:0]     score
);
    import miner_pkg::*;

    logic [9:0]              degree;
    trig_t                   trig;
    logic                    go_req;
    logic                    go_take;
    logic [item_index_w-1:0] claw_index;
    logic                    claw_we;
    item_t                   claw_wdata;
    item_t                   claw_rdata;
    logic                    add_en;
    item_kind_e              add_kind;

    rope_ctrl #(
        .frame_cycles (frame_cycles)
    ) i_rope_ctrl (.*);

    angle_trig i_angle_trig (.*);

    key_pulse i_key_pulse (
        .key (go_key),
        .*
    );

    item_ram i_item_ram (.*);

    score_counter i_score_counter (.*);

endmodule

`default_nettype wire

//--- rope_ctrl.sv
//--------------------------------------
// rope state machine. swings the rope,
// drops it on go, tests every item for a
// hit, reels in with the caught item and
// hands its kind to the score counter
//--------------------------------------
`default_nettype none
`timescale 1ns/1ps

module rope_ctrl #(
    parameter int frame_cycles = 833334
) (
    input  wire                                clock,
    input  wire                                resetn,
    input  wire                                enable,
    input  wire                                draw_busy,
    input  wire                                go_req,
    output logic                               go_take,
    output logic [9:0]                         degree,
    input  wire miner_pkg::trig_t              trig,
    output logic [miner_pkg::item_index_w-1:0] claw_index,
    output logic                               claw_we,
    output miner_pkg::item_t                   claw_wdata,
    input  wire miner_pkg::item_t              claw_rdata,
    output logic                               add_en,
    output miner_pkg::item_kind_e              add_kind,
    output miner_pkg::rope_pos_t               pos
);
    import miner_pkg::*;

    rope_state_e                         state;
    logic [$clog2(frame_cycles + 1)-1:0] frame_cnt;
    logic                                dir_up;     // survives a drop
    logic                                carrying;
    logic [17:0]                         len_fx;     // 8 fraction bits
    logic [9:0]                          len;
    logic [9:0]                          end_x;
    logic [9:0]                          end_y;
    logic [26:0]                         prod_x;
    logic [26:0]                         prod_y;
    logic [2:0]                          step_x;
    logic [2:0]                          step_y;
    item_t                               held;
    item_t                               moved;
    logic                                in_wait;
    logic                                frame_last;
    logic                                tick;
    logic                                edge_hit;
    logic                                item_hit;

    assign len        = len_fx[17:8];
    assign in_wait    = state inside {st_wait_swing, st_wait_down, st_wait_up};
    assign frame_last = (frame_cnt == frame_cycles - 1);
    assign tick       = in_wait && frame_last && !draw_busy;

    always_ff @(posedge clock) begin
        if (!resetn || !in_wait)
            frame_cnt <= '0;
        else if (!frame_last)
            frame_cnt <= frame_cnt + 1'b1;   // then hold while the drawer is busy
    end

    assign prod_x = len_fx * trig.cos;
    assign prod_y = len_fx * trig.sin;

    always_ff @(posedge clock) begin
        if (trig.cos_neg)
            end_x <= 10'(origin_x) - prod_x[25:16];
        else
            end_x <= 10'(origin_x) + prod_x[25:16];
        end_y <= 10'(origin_y) + prod_y[25:16];
    end

    assign edge_hit = (end_x <= 10'(edge_left)) || (end_x >= 10'(edge_right))
                   || (end_y >= 10'(edge_bottom)) || (len >= 10'(rope_max));
    assign item_hit = held.visible && !held.moving
                   && (10'(held.x) < end_x) && (end_x < 10'(held.x) + 10'(item_size))
                   && (10'(held.y) < end_y) && (end_y < 10'(held.y) + 10'(item_size));

    // carried item follows the rope end back toward the origin
    assign step_x = 3'((delta_len * trig.cos) >> 8);
    assign step_y = 3'((delta_len * trig.sin) >> 8);

    always_comb begin
        moved   = claw_rdata;
        moved.x = trig.cos_neg ? claw_rdata.x + 9'(step_x) : claw_rdata.x - 9'(step_x);
        moved.y = claw_rdata.y - 8'(step_y);
    end

    always_ff @(posedge clock) begin
        if (state == st_check_read)
            held <= claw_rdata;
        else if (state == st_carry_write)
            held <= moved;
    end

    always_ff @(posedge clock) begin
        if (!resetn) begin
            state      <= st_stop;
            degree     <= 10'(deg_start);
            len_fx     <= 18'(rope_min << 8);
            dir_up     <= 1'b0;
            carrying   <= 1'b0;
            claw_index <= '0;
        end else begin
            case (state)
                st_stop:
                    if (enable)
                        state <= st_wait_swing;
                st_wait_swing:
                    if (tick)
                        state <= st_swing;
                st_swing: begin
                    if (go_req) begin
                        state <= st_wait_down;   // degree frozen from here
                    end else begin
                        state <= st_wait_swing;
                        if (dir_up) begin
                            degree <= degree + 1'b1;
                            if (degree + 1'b1 >= 10'(deg_max))
                                dir_up <= 1'b0;
                        end else begin
                            degree <= degree - 1'b1;
                            if (degree - 1'b1 <= 10'(deg_min))
                                dir_up <= 1'b1;
                        end
                    end
                end
                st_wait_down:
                    if (tick)
                        state <= st_down;
                st_down: begin
                    len_fx     <= len_fx + 18'(delta_len << 8);
                    claw_index <= '0;
                    state      <= st_check_addr;
                end
                st_check_addr:
                    if (!draw_busy)
                        state <= st_check_read;   // address only counts when ours
                st_check_read:
                    state <= st_check_test;
                st_check_test: begin
                    if (edge_hit) begin
                        state <= st_wait_up;
                    end else if (item_hit) begin
                        carrying <= 1'b1;
                        state    <= st_wait_up;
                    end else if (claw_index == item_index_w'(item_count - 1)) begin
                        state <= st_wait_down;
                    end else begin
                        claw_index <= claw_index + 1'b1;
                        state      <= st_check_addr;
                    end
                end
                st_wait_up:
                    if (tick)
                        state <= st_up;
                st_up: begin
                    len_fx <= len_fx - 18'(delta_len << 8);
                    if (carrying)
                        state <= st_carry_read;
                    else if (len - 10'(delta_len) <= 10'(rope_min))
                        state <= st_wait_swing;
                    else
                        state <= st_wait_up;
                end
                st_carry_read:
                    if (!draw_busy)
                        state <= st_carry_write;
                st_carry_write:
                    state <= (len <= 10'(rope_min)) ? st_collect : st_wait_up;
                st_collect: begin
                    carrying <= 1'b0;
                    state    <= st_wait_swing;
                end
                default:
                    state <= st_stop;
            endcase
        end
    end

    assign go_take  = (state == st_swing) && go_req;
    assign add_en   = (state == st_collect);
    assign add_kind = held.kind;
    assign claw_we  = (state == st_check_test && !edge_hit && item_hit)
                   || (state == st_carry_write) || (state == st_collect);

    always_comb begin
        claw_wdata = held;
        case (state)
            st_check_test:  claw_wdata.moving = 1'b1;   // hooked
            st_carry_write: claw_wdata = moved;
            default: begin
                claw_wdata.visible = 1'b0;
                claw_wdata.moving  = 1'b0;
            end
        endcase
    end

    assign pos = '{degree: degree, len: len, end_x: end_x, end_y: end_y};

    a_degree_range: assert property (@(posedge clock) disable iff (!resetn)
        degree >= 10'(deg_min) && degree <= 10'(deg_max))
        else $error("rope angle outside the swing range");

    // reel in must land exactly on the rest length
    a_rest_len_swing: assert property (@(posedge clock) disable iff (!resetn)
        (state == st_swing) |-> (len == 10'(rope_min)))
        else $error("rope swings while not fully reeled in");

endmodule

`default_nettype wire

//--- score_counter.sv
//--------------------------------------
// score accumulator. adds the value of a
// collected item, sticks at the maximum
//--------------------------------------
`default_nettype none
`timescale 1ns/1ps

module score_counter (
    input  wire                            clock,
    input  wire                            resetn,
    input  wire                            add_en,
    input  wire miner_pkg::item_kind_e     add_kind,
    output logic [miner_pkg::score_w-1:0]  score
);
    import miner_pkg::*;

    logic [score_w-1:0] value;
    logic [score_w:0]   sum;   // carry bit flags overflow

    always_comb begin
        case (add_kind)
            kind_stone:   value = score_w'(value_stone);
            kind_gold:    value = score_w'(value_gold);
            kind_diamond: value = score_w'(value_diamond);
            default:      value = '0;
        endcase
    end

    assign sum = {1'b0, score} + {1'b0, value};

    always_ff @(posedge clock) begin
        if (!resetn)
            score <= '0;
        else if (add_en)
            score <= sum[score_w] ? '1 : sum[score_w-1:0];
    end

endmodule

`default_nettype wire

//--- item_ram.sv
//--------------------------------------
// 16 entry item memory, registered read
// the drawer owns the read address while
// busy, writes come from load or claw
//--------------------------------------
`default_nettype none
`timescale 1ns/1ps

module item_ram (
    input  wire                               clock,
    input  wire                               resetn,
    input  wire                               load_en,
    input  wire [miner_pkg::item_index_w-1:0] load_index,
    input  wire miner_pkg::item_t             load_item,
    input  wire                               draw_busy,
    input  wire [miner_pkg::item_index_w-1:0] draw_index,
    output miner_pkg::item_t                  draw_item,
    input  wire [miner_pkg::item_index_w-1:0] claw_index,
    input  wire                               claw_we,
    input  wire miner_pkg::item_t             claw_wdata,
    output miner_pkg::item_t                  claw_rdata
);
    import miner_pkg::*;

    item_t                   mem [item_count];
    item_t                   rd_q;
    logic [item_index_w-1:0] rd_addr;
    logic [item_index_w-1:0] wr_addr;
    item_t                   wr_data;

    assign rd_addr = draw_busy ? draw_index : claw_index;
    assign wr_addr = load_en ? load_index : claw_index;
    assign wr_data = load_en ? load_item : claw_wdata;

    always_ff @(posedge clock) begin
        if (!resetn) begin
            for (int i = 0; i < item_count; i++)
                mem[i].visible <= 1'b0;   // field starts empty
        end else if (load_en || claw_we) begin
            mem[wr_addr] <= wr_data;
        end
    end

    always_ff @(posedge clock)
        rd_q <= mem[rd_addr];

    assign draw_item  = rd_q;
    assign claw_rdata = rd_q;

    // loader and claw are separate masters
    a_one_writer: assert property (@(posedge clock) disable iff (!resetn)
        !(load_en && claw_we))
        else $error("load and claw write in the same cycle");

endmodule

`default_nettype wire

//--- key_pulse.sv
//--------------------------------------
// go key front end. synchronizes the key
// and keeps a go request pending from the
// rising edge until the controller takes it
//--------------------------------------
`default_nettype none
`timescale 1ns/1ps

module key_pulse (
    input  wire  clock,
    input  wire  resetn,
    input  wire  key,
    input  wire  go_take,
    output logic go_req
);

    logic [1:0] sync;
    logic       key_last;

    always_ff @(posedge clock) begin
        if (!resetn) begin
            sync     <= 2'b00;
            key_last <= 1'b0;
            go_req   <= 1'b0;
        end else begin
            sync     <= {sync[0], key};
            key_last <= sync[1];
            if (sync[1] && !key_last)
                go_req <= 1'b1;   // new press wins over a take
            else if (go_take)
                go_req <= 1'b0;
        end
    end

endmodule

`default_nettype wire

//--- angle_trig.sv
//--------------------------------------
// sine and cosine of the rope angle
// pure lookup, degree 0..180, results x 256
// above 90 the table is read mirrored
//--------------------------------------
`default_nettype none
`timescale 1ns/1ps

module angle_trig (
    input  wire [9:0]        degree,
    output miner_pkg::trig_t trig
);
    import miner_pkg::*;

    logic [9:0] deg_c;
    logic [6:0] fold;   // folded into 0..90

    always_comb begin
        deg_c = (degree > 10'd180) ? 10'd180 : degree;
        if (deg_c > 10'd90)
            fold = 7'(10'd180 - deg_c);
        else
            fold = 7'(deg_c);
        trig.sin     = sin_table[fold];
        trig.cos     = sin_table[7'd90 - fold];
        trig.cos_neg = (deg_c > 10'd90);
    end

endmodule

`default_nettype wire

//--- miner_pkg.sv
//--------------------------------------
// shared types and constants for the claw
// subsystem. every block pulls these in by
// import, ports use scoped names
//--------------------------------------
`default_nettype none

package miner_pkg;

    typedef enum logic [1:0] {
        kind_stone   = 2'd0,
        kind_gold    = 2'd1,
        kind_diamond = 2'd2,
        kind_none    = 2'd3
    } item_kind_e;

    typedef struct packed {
        logic [8:0]  x;        // left edge
        logic [7:0]  y;        // top edge
        logic [10:0] spare;
        item_kind_e  kind;
        logic        visible;
        logic        moving;   // hooked on the rope
    } item_t;

    typedef struct packed {
        logic [8:0] sin;       // x 256
        logic [8:0] cos;
        logic       cos_neg;   // end point left of origin
    } trig_t;

    typedef struct packed {
        logic [9:0] degree;
        logic [9:0] len;
        logic [9:0] end_x;
        logic [9:0] end_y;
    } rope_pos_t;

    typedef enum logic [3:0] {
        st_stop,
        st_wait_swing, st_swing,
        st_wait_down, st_down,
        st_check_addr, st_check_read, st_check_test,
        st_wait_up, st_up,
        st_carry_read, st_carry_write,
        st_collect
    } rope_state_e;

    localparam int origin_x      = 160;
    localparam int origin_y      = 45;
    localparam int rope_min      = 20;
    localparam int rope_max      = 275;
    localparam int delta_len     = 2;    // pixels per frame
    localparam int deg_min       = 15;
    localparam int deg_max       = 165;
    localparam int deg_start     = 165;
    localparam int edge_left     = 10;
    localparam int edge_right    = 310;
    localparam int edge_bottom   = 230;
    localparam int item_size     = 16;
    localparam int item_count    = 16;
    localparam int item_index_w  = 4;
    localparam int score_w       = 10;
    localparam int value_stone   = 1;
    localparam int value_gold    = 2;
    localparam int value_diamond = 5;

    // round(sin(d) * 256) for d = 0..90
    localparam logic [8:0] sin_table [0:90] = '{
          0,   4,   9,  13,  18,  22,  27,  31,  36,  40,
         44,  49,  53,  58,  62,  66,  71,  75,  79,  83,
         88,  92,  96, 100, 104, 108, 112, 116, 120, 124,
        128, 132, 136, 139, 143, 147, 150, 154, 158, 161,
        165, 168, 171, 175, 178, 181, 184, 187, 190, 193,
        196, 199, 202, 204, 207, 210, 212, 215, 217, 219,
        222, 224, 226, 228, 230, 232, 234, 236, 237, 239,
        241, 242, 243, 245, 246, 247, 248, 249, 250, 251,
        252, 253, 254, 254, 255, 255, 255, 256, 256, 256,
        256
    };

endpackage

`default_nettype wire
